//--- Bender.yml
package:
  name: pixel_readout

export_include_dirs:
  - hw

sources:
  - files:
      - hw/pixel_readout_pkg.sv
      - hw/rr_arbiter.sv
      - hw/hit_latch_array.sv
      - hw/hit_fifo.sv
      - hw/readout_sequencer.sv
      - hw/wb_readout_regs.sv
      - hw/pixel_readout_top.sv
  - target: simulation
    files:
      - bench/pixel_readout_properties.sv
      - bench/pixel_readout_checker.sv
      - bench/pixel_readout_tb.sv

//--- bench/pixel_readout_checker.sv
// pixel readout checker
// reference model of latches, row and column round-robin order and FIFO capacity
// compares every Wishbone read against the model and counts errors
`include "pixel_readout_macros.svh"

module pixel_readout_checker import pixel_readout_pkg::*; (
    input logic                           clk_i,
    input logic                           reset_i,
    input logic [`PIX_ROWS*`PIX_COLS-1:0] hit_i,
    input logic                           cyc_i,
    input logic                           stb_i,
    input logic                           we_i,
    input logic [`WB_AW-1:0]              adr_i,
    input logic [`WB_DW-1:0]              dat_i,
    input logic [`WB_DW/8-1:0]            sel_i,
    input logic [`WB_DW-1:0]              rd_data_i,
    input logic                           ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`PIX_ROWS*`PIX_COLS-1:0] latch_m;
    logic [5:0]                     fifo_m [$];
    seq_state_t                     state_m;
    int                             row_last;
    int                             col_last;
    int                             row_g;
    int                             col_g;
    logic                           run_m;
    logic                           busy;
    int                             valid_reads = 0;
    int                             errors = 0;

    // lowest request above last, else wrap to the lowest request
    function automatic int rr_pick(input logic [7:0] req, input int last);
        for (int i = last + 1; i < 8; i++)
        begin
            if (req[i])
            begin
                return i;
            end
        end
        for (int i = 0; i < 8; i++)
        begin
            if (req[i])
            begin
                return i;
            end
        end
        return 0;
    endfunction

    function automatic logic [7:0] row_reqs(input logic [`PIX_ROWS*`PIX_COLS-1:0] lat);
        logic [7:0] r;
        for (int i = 0; i < `PIX_ROWS; i++)
        begin
            r[i] = |lat[i*`PIX_COLS +: `PIX_COLS];
        end
        return r;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s read returned %h, expected %h",
                     $time, what, got, exp);
        end
    endtask

    // addresses seen since the last drain versus unique pixels hit
    task automatic check_drain(input int exp_reads);
        if (valid_reads != exp_reads)
        begin
            errors++;
            $display("CHECK FAILED at %0t: drain gave %0d addresses, expected %0d",
                     $time, valid_reads, exp_reads);
        end
        valid_reads = 0;
    endtask

    always @(posedge clk_i or posedge reset_i)
    begin : model_step
        int          qn;
        logic        run_pre;
        logic [31:0] exp;
        if (reset_i)
        begin
            latch_m = '0;
            fifo_m.delete();
            state_m = IDLE;
            // mask open, first grant is the lowest request
            row_last = -1;
            col_last = -1;
            row_g = 0;
            col_g = 0;
            run_m = 1'b0;
        end
        else
        begin
            // pre-edge values, as the DUT sees them
            qn = fifo_m.size();
            run_pre = run_m;
            exp = '0;
            if (ack_i && cyc_i && stb_i)
            begin
                if (we_i)
                begin
                    if (reg_offset_t'(adr_i[3:2]) == REG_CTRL && sel_i[0])
                    begin
                        run_m = dat_i[0];
                    end
                end
                else if (reg_offset_t'(adr_i[3:2]) == REG_STATUS)
                begin
                    exp[0] = (qn == 0);
                    exp[1] = (qn == `HIT_FIFO_DEPTH);
                    exp[7:4] = 4'(qn);
                    compare("status", rd_data_i, exp);
                end
                else if (reg_offset_t'(adr_i[3:2]) == REG_DATA)
                begin
                    // empty FIFO reads back zero
                    if (qn != 0)
                    begin
                        exp = {1'b1, 25'b0, fifo_m.pop_front()};
                    end
                    compare("data", rd_data_i, exp);
                    // addresses the DUT actually handed out
                    if (rd_data_i[`WB_DW-1] === 1'b1)
                    begin
                        valid_reads++;
                    end
                end
            end
            case (state_m)
                IDLE:
                begin
                    if (run_pre && latch_m != '0 && qn < `HIT_FIFO_DEPTH)
                    begin
                        state_m = ROW_SEL;
                    end
                end
                ROW_SEL:
                begin
                    row_g = rr_pick(row_reqs(latch_m), row_last);
                    row_last = row_g;
                    state_m = COL_SEL;
                end
                COL_SEL:
                begin
                    // column pointer carries over between rows
                    col_g = rr_pick(latch_m[row_g*`PIX_COLS +: `PIX_COLS], col_last);
                    col_last = col_g;
                    state_m = PUSH;
                end
                default:
                begin
                    if (qn < `HIT_FIFO_DEPTH)
                    begin
                        fifo_m.push_back({3'(row_g), 3'(col_g)});
                    end
                    latch_m[row_g*`PIX_COLS + col_g] = 1'b0;
                    state_m = IDLE;
                end
            endcase
            // new hit wins over a clear
            latch_m = latch_m | hit_i;
        end
        busy = (latch_m != '0) || (fifo_m.size() != 0) || (state_m != IDLE);
    end

endmodule

//--- bench/pixel_readout_properties.sv
// pixel readout assertions
// Wishbone ack handshake and FIFO flag checks, bound into the slave and the FIFO
module pixel_readout_properties (
    input logic clk_i,
    input logic reset_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic push_i,
    input logic full_i,
    input logic empty_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // ack exactly one clock after a fresh request
    ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
        (cyc_i && stb_i && !ack_i) |=> ack_i)
        else
        begin
            fail_count++;
            $error("ack did not follow the request by one cycle");
        end

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |=> !ack_i)
        else
        begin
            fail_count++;
            $error("ack held for more than one cycle");
        end

    flags_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(full_i && empty_i))
        else
        begin
            fail_count++;
            $error("FIFO full and empty at the same time");
        end

    // sequencer must wait in IDLE while full
    no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        !(push_i && full_i))
        else
        begin
            fail_count++;
            $error("push while the FIFO is full");
        end

endmodule

bind wb_readout_regs pixel_readout_properties props_regs (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .ack_i   (ack_o),
    .push_i  (1'b0),
    .full_i  (fifo.full),
    .empty_i (fifo.empty)
);

bind hit_fifo pixel_readout_properties props_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cyc_i   (1'b0),
    .stb_i   (1'b0),
    .ack_i   (1'b0),
    .push_i  (port.push),
    .full_i  (port.full),
    .empty_i (port.empty)
);

//--- bench/pixel_readout_tb.sv
// pixel readout testbench
// hit patterns and run settings from a table, Wishbone master reads and drains
`include "pixel_readout_macros.svh"

module pixel_readout_tb import pixel_readout_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_STEPS    = 7;
    localparam int ACK_LIMIT    = 16;
    localparam int STATUS_LIMIT = 64;
    localparam int DRAIN_LIMIT  = 400;

    typedef struct packed {
        logic [63:0] hits;
        logic        run;
        logic [3:0]  reads;
        logic        chk_status;
        logic [7:0]  exp_status;
        logic        add_random;
    } step_t;

    // hits, run, data reads, status check, expected status, random extra hits
    localparam step_t STEPS [NUM_STEPS] = '{
        '{64'h0, 1'b0, 4'd1, 1'b1, 8'h01, 1'b0},
        '{64'h0000_0081_0000_2400, 1'b0, 4'd2, 1'b1, 8'h01, 1'b0},
        // row 1 and row 4 pixels hit again while still pending
        '{64'h0300_0081_0000_2418, 1'b1, 4'd0, 1'b0, 8'h00, 1'b0},
        // more hits than FIFO entries, so it fills
        '{64'h8040_2010_0804_0201, 1'b1, 4'd0, 1'b1, 8'h42, 1'b0},
        '{64'h0, 1'b1, 4'd0, 1'b0, 8'h00, 1'b1},
        '{64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 4'd0, 1'b1, 8'h42, 1'b0},
        '{64'h0, 1'b0, 4'd1, 1'b1, 8'h01, 1'b0}
    };

    logic                           clk;
    logic                           reset;
    logic [`PIX_ROWS*`PIX_COLS-1:0] hit;
    logic                           cyc;
    logic                           stb;
    logic                           we;
    logic [`WB_AW-1:0]              adr;
    logic [`WB_DW-1:0]              wdat;
    logic [`WB_DW/8-1:0]            sel;
    logic [`WB_DW-1:0]              rdat;
    logic                           ack;
    // unique pixels hit since the last drain
    logic [`PIX_ROWS*`PIX_COLS-1:0] pend;
    logic [`WB_DW-1:0]              rd;
    integer                         seed;
    int                             timeouts;
    int                             assert_fails;

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    pixel_readout_top dut0 (
        .clk_i   (clk),
        .reset_i (reset),
        .hit_i   (hit),
        .cyc_i   (cyc),
        .stb_i   (stb),
        .we_i    (we),
        .adr_i   (adr),
        .dat_i   (wdat),
        .sel_i   (sel),
        .dat_o   (rdat),
        .ack_o   (ack)
    );

    pixel_readout_checker checker0 (
        .clk_i     (clk),
        .reset_i   (reset),
        .hit_i     (hit),
        .cyc_i     (cyc),
        .stb_i     (stb),
        .we_i      (we),
        .adr_i     (adr),
        .dat_i     (wdat),
        .sel_i     (sel),
        .rd_data_i (rdat),
        .ack_i     (ack)
    );

    // one classic transfer, stb held through the ack cycle
    task automatic bus_access(input logic write, input reg_offset_t offset,
                              input logic [`WB_DW-1:0] data, output logic [`WB_DW-1:0] result);
        int waited;
        waited = 0;
        result = '0;
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = {offset, 2'b00};
        wdat = data;
        sel  = '1;
        @(negedge clk);
        while (!ack && waited < ACK_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (ack)
        begin
            result = rdat;
        end
        else
        begin
            timeouts++;
            $display("timeout at %0t: no Wishbone ack for register %0d", $time, offset);
        end
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // single-cycle pulse
    task automatic apply_hits(input logic [`PIX_ROWS*`PIX_COLS-1:0] pattern);
        @(negedge clk);
        hit = pattern;
        pend = pend | pattern;
        @(negedge clk);
        hit = '0;
    endtask

    task automatic wait_status(input logic [7:0] want);
        int polls;
        polls = 0;
        bus_access(1'b0, REG_STATUS, '0, rd);
        while (rd[7:0] != want && polls < STATUS_LIMIT)
        begin
            bus_access(1'b0, REG_STATUS, '0, rd);
            polls++;
        end
        if (rd[7:0] != want)
        begin
            timeouts++;
            $display("timeout at %0t: status stuck at %h, waiting for %h", $time, rd[7:0], want);
        end
    endtask

    // read data until the model has nothing left, then one empty read
    task automatic drain();
        int tries;
        tries = 0;
        while (checker0.busy && tries < DRAIN_LIMIT)
        begin
            bus_access(1'b0, REG_DATA, '0, rd);
            tries++;
        end
        if (checker0.busy)
        begin
            timeouts++;
            $display("timeout at %0t: hits still pending after %0d reads", $time, tries);
        end
        bus_access(1'b0, REG_DATA, '0, rd);
        checker0.check_drain($countones(pend));
        pend = '0;
    endtask

    initial
    begin
        logic [`PIX_ROWS*`PIX_COLS-1:0] pattern;
        seed     = 32'h34330ed7;
        timeouts = 0;
        pend     = '0;
        reset    = 1'b1;
        hit      = '0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        wdat     = '0;
        sel      = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_STEPS; i++)
        begin
            pattern = STEPS[i].hits;
            if (STEPS[i].add_random)
            begin
                pattern = pattern | {32'($random(seed)), 32'($random(seed))};
            end
            // hits land before run changes, so repeats stay pending
            apply_hits(pattern);
            bus_access(1'b1, REG_CTRL, {31'b0, STEPS[i].run}, rd);
            for (int r = 0; r < STEPS[i].reads; r++)
            begin
                bus_access(1'b0, REG_DATA, '0, rd);
            end
            if (STEPS[i].chk_status)
            begin
                wait_status(STEPS[i].exp_status);
            end
            if (STEPS[i].run)
            begin
                drain();
            end
        end
        assert_fails = dut0.u_regs.props_regs.fail_count + dut0.u_fifo.props_fifo.fail_count;
        $display("summary: %0d check errors, %0d timeouts, %0d assertion failures",
                 checker0.errors, timeouts, assert_fails);
        if (checker0.errors + timeouts + assert_fails == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- hw/hit_fifo.sv
// hit address FIFO with its connecting interface
// first-word fall-through circular buffer, push ignored when full, pop when empty
`include "pixel_readout_macros.svh"

interface hit_fifo_if import pixel_readout_pkg::*; ();
    logic                                   push;
    hit_addr_t                              push_data;
    logic                                   full;
    logic                                   pop;
    hit_addr_t                              pop_data;
    logic                                   empty;
    logic [$clog2(`HIT_FIFO_DEPTH + 1)-1:0] level;

    modport writer (output push, output push_data, input full);
    modport store (
        input  push, input  push_data, input  pop,
        output full, output pop_data,  output empty, output level
    );
    modport reader (output pop, input pop_data, input empty, input full, input level);
endinterface

module hit_fifo import pixel_readout_pkg::*; (
    input logic       clk_i,
    input logic       reset_i,
    hit_fifo_if.store port
);
    localparam int DEPTH = `HIT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = $clog2(DEPTH + 1);

    hit_addr_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [LVL_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign port.full  = (count == LVL_W'(DEPTH));
    assign port.empty = (count == '0);
    assign port.level = count;
    assign do_push    = port.push & ~port.full;
    assign do_pop     = port.pop & ~port.empty;

    // head word always visible
    assign port.pop_data = mem[rd_ptr];

    always_ff @(posedge clk_i)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= port.push_data;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap at the last entry
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/hit_latch_array.sv
// sticky hit latches for the whole pixel matrix
// one row request per row, single addressed pixel cleared after readout
`include "pixel_readout_macros.svh"

module hit_latch_array import pixel_readout_pkg::*; (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic [`PIX_ROWS*`PIX_COLS-1:0]   hit_i,
    input  logic                             clear_i,
    input  hit_addr_t                        clear_addr_i,
    output logic [`PIX_ROWS*`PIX_COLS-1:0]   pixels_o,
    output logic [`PIX_ROWS-1:0]             row_req_o
);
    logic [`PIX_ROWS*`PIX_COLS-1:0] latch_q;
    logic [`PIX_ROWS*`PIX_COLS-1:0] clear_mask;

    // one-hot mask of the pixel being read out
    always_comb
    begin
        clear_mask = '0;
        if (clear_i)
        begin
            clear_mask[int'(clear_addr_i.row) * `PIX_COLS + int'(clear_addr_i.col)] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            latch_q <= '0;
        end
        else
        begin
            // fresh hit beats a clear on the same pixel
            latch_q <= (latch_q & ~clear_mask) | hit_i;
        end
    end

    assign pixels_o = latch_q;

    // or-reduce each row
    for (genvar r = 0; r < `PIX_ROWS; r++)
    begin : g_row_req
        assign row_req_o[r] = |latch_q[r*`PIX_COLS +: `PIX_COLS];
    end

endmodule

//--- hw/pixel_readout_macros.svh
// pixel readout sizing
// matrix geometry, hit address widths, FIFO depth and Wishbone bus widths
`ifndef PIXEL_READOUT_MACROS_SVH
`define PIXEL_READOUT_MACROS_SVH

// matrix geometry
`define PIX_ROWS 8
`define PIX_COLS 8

// index widths, log2 of rows and cols
`define PIX_ROW_W 3
`define PIX_COL_W 3

// kept small so back-pressure shows up quickly
`define HIT_FIFO_DEPTH 4

// Wishbone classic slave widths
`define WB_DW 32
`define WB_AW 4

`endif

//--- hw/pixel_readout_pkg.sv
// pixel readout shared types
// hit address, sequencer states and register word offsets
`include "pixel_readout_macros.svh"

package pixel_readout_pkg;

    // row in the upper bits, column in the lower bits
    typedef struct packed {
        logic [`PIX_ROW_W-1:0] row;
        logic [`PIX_COL_W-1:0] col;
    } hit_addr_t;

    // one pass per hit
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ROW_SEL = 2'd1,
        COL_SEL = 2'd2,
        PUSH    = 2'd3
    } seq_state_t;

    // word offsets, taken from adr_i[3:2]
    typedef enum logic [1:0] {
        REG_STATUS = 2'd0,
        REG_DATA   = 2'd1,
        REG_CTRL   = 2'd2
    } reg_offset_t;

endpackage

//--- hw/pixel_readout_top.sv
// pixel matrix readout top level
// latches, sequencer, FIFO and Wishbone registers on plain ports
`include "pixel_readout_macros.svh"

module pixel_readout_top import pixel_readout_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [`PIX_ROWS*`PIX_COLS-1:0] hit_i,
    input  logic                           cyc_i,
    input  logic                           stb_i,
    input  logic                           we_i,
    input  logic [`WB_AW-1:0]              adr_i,
    input  logic [`WB_DW-1:0]              dat_i,
    input  logic [`WB_DW/8-1:0]            sel_i,
    output logic [`WB_DW-1:0]              dat_o,
    output logic                           ack_o
);
    logic [`PIX_ROWS*`PIX_COLS-1:0] pixels;
    logic [`PIX_ROWS-1:0]           row_req;
    logic                           clear;
    hit_addr_t                      clear_addr;
    logic                           run;

    // sequencer to FIFO to registers
    hit_fifo_if fifo_if ();

    hit_latch_array u_latch (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .hit_i        (hit_i),
        .clear_i      (clear),
        .clear_addr_i (clear_addr),
        .pixels_o     (pixels),
        .row_req_o    (row_req)
    );

    readout_sequencer u_seq (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .run_i        (run),
        .row_req_i    (row_req),
        .pixels_i     (pixels),
        .clear_o      (clear),
        .clear_addr_o (clear_addr),
        .fifo         (fifo_if.writer)
    );

    hit_fifo u_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .port    (fifo_if.store)
    );

    wb_readout_regs u_regs (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .adr_i   (adr_i),
        .dat_i   (dat_i),
        .sel_i   (sel_i),
        .dat_o   (dat_o),
        .ack_o   (ack_o),
        .fifo    (fifo_if.reader),
        .run_o   (run)
    );

endmodule

//--- hw/readout_sequencer.sv
// readout sequencer
// steps row then column arbitration and pushes one hit address per pass
`include "pixel_readout_macros.svh"

module readout_sequencer import pixel_readout_pkg::*; (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           run_i,
    input  logic [`PIX_ROWS-1:0]           row_req_i,
    input  logic [`PIX_ROWS*`PIX_COLS-1:0] pixels_i,
    output logic                           clear_o,
    output hit_addr_t                      clear_addr_o,
    hit_fifo_if.writer                     fifo
);
    seq_state_t             state_q;
    seq_state_t             state_d;
    logic                   row_en;
    logic                   col_en;
    logic [`PIX_ROWS-1:0]   row_gnt;
    logic [`PIX_ROW_W-1:0]  row_idx;
    logic [`PIX_COLS-1:0]   col_req;
    logic [`PIX_COL_W-1:0]  col_idx;
    hit_addr_t              cur_addr;

    // next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                // hold here while the FIFO is full, latches keep the hits
                if (run_i && (|row_req_i) && !fifo.full)
                begin
                    state_d = ROW_SEL;
                end
            end
            ROW_SEL: state_d = COL_SEL;
            COL_SEL: state_d = PUSH;
            PUSH:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    assign row_en = (state_q == ROW_SEL);
    assign col_en = (state_q == COL_SEL);

    // pixel bits of the granted row, and-or over the one-hot row grant
    always_comb
    begin
        col_req = '0;
        for (int r = 0; r < `PIX_ROWS; r++)
        begin
            if (row_gnt[r])
            begin
                col_req = col_req | pixels_i[r*`PIX_COLS +: `PIX_COLS];
            end
        end
    end

    rr_arbiter #(.WIDTH(`PIX_ROWS)) row_arb (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (row_en),
        .req_i    (row_req_i),
        .gnt_o    (row_gnt),
        .idx_o    (row_idx)
    );

    // column pointer persists across rows
    rr_arbiter #(.WIDTH(`PIX_COLS)) col_arb (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (col_en),
        .req_i    (col_req),
        .gnt_o    (),
        .idx_o    (col_idx)
    );

    assign cur_addr.row = row_idx;
    assign cur_addr.col = col_idx;

    // write and clear together in PUSH
    assign fifo.push      = (state_q == PUSH);
    assign fifo.push_data = cur_addr;
    assign clear_o        = (state_q == PUSH);
    assign clear_addr_o   = cur_addr;

endmodule

//--- hw/rr_arbiter.sv
// round-robin arbiter with a registered one-hot grant
// requests above the last grant win first, otherwise wrap to the lowest request
module rr_arbiter #(
    parameter int WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     enable_i,
    input  logic [WIDTH-1:0]         req_i,
    output logic [WIDTH-1:0]         gnt_o,
    output logic [$clog2(WIDTH)-1:0] idx_o
);
    localparam int IDX_W = $clog2(WIDTH);

    logic [WIDTH-1:0] mask_q;
    logic [WIDTH-1:0] mask_req;
    logic [WIDTH-1:0] mask_gnt;
    logic [WIDTH-1:0] raw_gnt;
    logic [WIDTH-1:0] gnt_next;
    logic [WIDTH-1:0] mask_next;

    // lowest set bit only
    function automatic logic [WIDTH-1:0] lowest_bit(input logic [WIDTH-1:0] vec);
        return vec & (~vec + WIDTH'(1));
    endfunction

    // one-hot to binary, zero when nothing granted
    function automatic logic [IDX_W-1:0] encode(input logic [WIDTH-1:0] onehot);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < WIDTH; i++)
        begin
            if (onehot[i])
            begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // requests strictly above the previous grant
    assign mask_req = req_i & mask_q;
    assign mask_gnt = lowest_bit(mask_req);
    assign raw_gnt  = lowest_bit(req_i);

    // wrap to raw when nothing left above the pointer
    assign gnt_next = (|mask_req) ? mask_gnt : raw_gnt;

    // bits above the new grant, keep old pointer on an empty request
    assign mask_next = (|req_i) ? ~((gnt_next << 1) - WIDTH'(1)) : mask_q;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            // every request allowed, nothing granted
            mask_q <= '1;
            gnt_o  <= '0;
        end
        else if (enable_i)
        begin
            mask_q <= mask_next;
            gnt_o  <= gnt_next;
        end
    end

    // index follows the registered grant
    assign idx_o = encode(gnt_o);

endmodule

//--- hw/wb_readout_regs.sv
// Wishbone classic register slave for the readout
// status word, FIFO data pop on read, run enable in control
`include "pixel_readout_macros.svh"

module wb_readout_regs import pixel_readout_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cyc_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [`WB_AW-1:0]    adr_i,
    input  logic [`WB_DW-1:0]    dat_i,
    input  logic [`WB_DW/8-1:0]  sel_i,
    output logic [`WB_DW-1:0]    dat_o,
    output logic                 ack_o,
    hit_fifo_if.reader           fifo,
    output logic                 run_o
);
    reg_offset_t        offset;
    logic               wb_req;
    logic               wb_ack;
    logic               run_q;
    logic [`WB_DW-1:0]  rd_word;

    // word address, byte lanes dropped
    assign offset = reg_offset_t'(adr_i[3:2]);
    assign wb_req = cyc_i & stb_i;
    // cycle where the transfer completes
    assign wb_ack = ack_o & wb_req;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ack_o <= 1'b0;
            run_q <= 1'b0;
        end
        else
        begin
            // one ack per request, one clock late
            ack_o <= wb_req & ~ack_o;
            if (wb_ack && we_i && offset == REG_CTRL && sel_i[0])
            begin
                run_q <= dat_i[0];
            end
        end
    end

    // read mux, evaluated on the ack cycle
    always_comb
    begin
        rd_word = '0;
        case (offset)
            REG_STATUS:
            begin
                rd_word[0]   = fifo.empty;
                rd_word[1]   = fifo.full;
                rd_word[7:4] = 4'(fifo.level);
            end
            REG_DATA:
            begin
                // valid flag plus row/col, zero when empty
                if (!fifo.empty)
                begin
                    rd_word[`WB_DW-1] = 1'b1;
                    rd_word[5:0]      = fifo.pop_data;
                end
            end
            REG_CTRL: rd_word[0] = run_q;
            default:  rd_word = '0;
        endcase
    end

    assign dat_o = ack_o ? rd_word : '0;
    // pop in the same cycle the head is returned
    assign fifo.pop = wb_ack & ~we_i & (offset == REG_DATA) & ~fifo.empty;
    assign run_o    = run_q;

endmodule

//--- sim.f
+incdir+hw
hw/pixel_readout_pkg.sv
hw/rr_arbiter.sv
hw/hit_latch_array.sv
hw/hit_fifo.sv
hw/readout_sequencer.sv
hw/wb_readout_regs.sv
hw/pixel_readout_top.sv
bench/pixel_readout_properties.sv
bench/pixel_readout_checker.sv
bench/pixel_readout_tb.sv
